// ==== bench/icrc_insert_asserts.sv ====
`timescale 1ns/1ps

module icrc_insert_asserts (
    input logic                clk,
    input logic                rst,
    input axis_pkg::out_beat_t out_beat,
    input logic                out_valid,
    input logic                out_ready
);

    // a stalled beat holds until the sink takes it
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while stalled");

    // keep is a run of ones starting at byte 0
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_beat.keep[0] && ((out_beat.keep & (out_beat.keep + 1)) == 0))
        else $error("output keep not contiguous from byte 0");

    assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after reset");

endmodule

bind roce_icrc_insert icrc_insert_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

// ==== bench/tb_roce_icrc_insert.sv ====
`timescale 1ns/1ps

module tb_roce_icrc_insert;

    import axis_pkg::*;

    logic       clk;
    logic       rst;
    axis_beat_t in_beat;
    logic       in_valid;
    logic       in_ready;
    out_beat_t  out_beat;
    logic       out_valid;
    logic       out_ready;

    out_beat_t   exp_q[$];
    logic [7:0]  frame_bytes[$];
    bit          random_ready;
    int          beats_sent;
    int          cycles;

    roce_icrc_insert dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // variant fields of ipv4, udp and bth
    function automatic bit is_masked(input int off);
        return off == 1 || off == 8 || off == 10 || off == 11 ||
               off == 26 || off == 27 || off == 32;
    endfunction

    // byte-serial reflected crc-32 over the 0xff prefix and the masked frame
    function automatic logic [31:0] ref_icrc();
        logic [31:0] c;
        logic [7:0]  b;
        c = 32'hFFFF_FFFF;
        for (int i = -8; i < frame_bytes.size(); i++) begin
            b = (i < 0 || is_masked(i)) ? 8'hFF : frame_bytes[i];
            c = c ^ {24'h0, b};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
            end
        end
        return ~c;
    endfunction

    task automatic build_frame(input int len);
        frame_bytes.delete();
        for (int i = 0; i < len; i++) begin
            frame_bytes.push_back(8'($urandom));
        end
    endtask

    task automatic send_frame(input bit roce, input bit bad);
        logic [7:0]  obytes[$];
        logic [31:0] icrc;
        axis_beat_t  beat;
        out_beat_t   ob;
        obytes = frame_bytes;
        if (roce && !bad) begin
            icrc = ref_icrc();
            for (int k = 0; k < 4; k++) begin
                obytes.push_back(icrc[8*k +: 8]);
            end
        end
        for (int i = 0; i < obytes.size(); i += 8) begin
            ob = '0;
            for (int k = 0; k < 8 && i + k < obytes.size(); k++) begin
                ob.data[8*k +: 8] = obytes[i+k];
                ob.keep[k]        = 1'b1;
            end
            ob.last = i + 8 >= obytes.size();
            ob.user = ob.last && bad;
            exp_q.push_back(ob);
        end
        for (int i = 0; i < frame_bytes.size(); i += 8) begin
            beat = '0;
            for (int k = 0; k < 8 && i + k < frame_bytes.size(); k++) begin
                beat.data[8*k +: 8] = frame_bytes[i+k];
                beat.keep[k]        = 1'b1;
            end
            beat.last = i + 8 >= frame_bytes.size();
            beat.user = {roce, bad};
            in_beat   = beat;
            in_valid  = 1'b1;
            while (!in_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
            beats_sent++;
        end
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic icrc_in_last_beat();
        build_frame(52);
        send_frame(1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic icrc_extra_beat();
        build_frame(56);
        send_frame(1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic non_roce_passthrough();
        build_frame(44);
        send_frame(1'b0, 1'b0);
        wait_drain();
    endtask

    task automatic malformed_then_good();
        build_frame(60);
        send_frame(1'b1, 1'b1);
        build_frame(40);
        send_frame(1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic icrc_invariance();
        build_frame(48);
        send_frame(1'b1, 1'b0);
        wait_drain();
        // only masked bytes change, so both frames expect the same icrc
        for (int i = 0; i < 48; i++) begin
            if (is_masked(i)) begin
                frame_bytes[i] = ~frame_bytes[i];
            end
        end
        send_frame(1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic mixed_backpressure();
        int kind;
        random_ready = 1'b1;
        for (int f = 0; f < 10; f++) begin
            build_frame(8 + 4 * ($urandom % 15));
            kind = $urandom % 3;
            send_frame(kind != 0, kind == 2);
        end
        wait_drain();
        random_ready = 1'b0;
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat arrived at %0t ns with none expected", $time);
                $display("ERRORS FOUND");
                $fatal(1);
            end else begin
                check("out_beat.data", out_beat.data, exp_q[0].data);
                check("out_beat.keep", 64'(out_beat.keep), 64'(exp_q[0].keep));
                check("out_beat.last", 64'(out_beat.last), 64'(exp_q[0].last));
                check("out_beat.user", 64'(out_beat.user), 64'(exp_q[0].user));
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        #1;
        out_ready = random_ready ? 1'($urandom % 2) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > beats_sent * 4 + 200) begin
            $display("timeout after %0d cycles with %0d beats still expected", cycles,
                     exp_q.size());
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(54448));
        rst          = 1'b1;
        in_beat      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        random_ready = 1'b0;
        beats_sent   = 0;
        cycles       = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        icrc_in_last_beat();
        icrc_extra_beat();
        non_roce_passthrough();
        malformed_then_good();
        icrc_invariance();
        mixed_backpressure();
        repeat (10) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("%0d expected output beats never arrived", exp_q.size());
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

// ==== files.f ====
source/axis_pkg.sv
source/roce_pkg.sv
source/icrc_field_mask.sv
source/icrc_crc32_calc.sv
source/beat_fifo.sv
source/icrc_append.sv
source/roce_icrc_insert.sv
bench/icrc_insert_asserts.sv
bench/tb_roce_icrc_insert.sv

// ==== source/axis_pkg.sv ====
package axis_pkg;

    // 64-bit stream, one keep bit per byte
    localparam int data_width = 64;
    localparam int keep_width = data_width / 8;

    // input beat, user[0] malformed, user[1] roce
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        logic                  last;
        logic [1:0]            user;
    } axis_beat_t;

    // output beat, user flags a malformed frame
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        logic                  last;
        logic                  user;
    } out_beat_t;

endpackage

// ==== source/beat_fifo.sv ====
`timescale 1ns/1ps

module beat_fifo #(
    parameter int width = 32,
    parameter int depth = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [width-1:0]             wr_data,
    input  logic                         wr_en,
    output logic [width-1:0]             rd_data,
    input  logic                         rd_en,
    output logic                         not_empty,
    output logic [$clog2(depth+1)-1:0]   free_count
);

    logic [width-1:0]           mem [depth];
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr      = wr_en && count != depth;
    assign do_rd      = rd_en && not_empty;
    assign not_empty  = count != '0;
    assign free_count = ($clog2(depth+1))'(depth) - count;

    // head is always presented
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr == ($clog2(depth))'(depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr == ($clog2(depth))'(depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/icrc_append.sv ====
`timescale 1ns/1ps

module icrc_append (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t frame_head,
    input  logic                 frame_ready,
    output logic                 frame_pop,
    input  logic [31:0]          crc_head,
    input  logic                 crc_ready,
    output logic                 crc_pop,
    output axis_pkg::out_beat_t  out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    import axis_pkg::*;
    import roce_pkg::*;

    typedef enum logic {
        st_pass,
        st_tail
    } state_t;

    state_t      state;
    state_t      state_next;
    out_beat_t   out_next;
    logic [31:0] crc_hold;
    logic        can_load;
    logic        need_crc;
    logic        malformed;
    logic        take;
    logic        load;

    assign can_load  = !out_valid || out_ready;
    assign need_crc  = frame_head.last && frame_head.user[user_roce_bit];
    assign malformed = frame_head.user[user_malformed_bit];

    // last roce beat waits for its crc so both leave together
    assign take      = state == st_pass && can_load && frame_ready && (!need_crc || crc_ready);
    assign frame_pop = take;
    assign crc_pop   = take && need_crc;
    assign load      = take || (state == st_tail && can_load);

    always_comb begin
        state_next    = state;
        out_next.data = frame_head.data;
        out_next.keep = frame_head.keep;
        out_next.last = frame_head.last;
        out_next.user = frame_head.last && malformed;

        if (state == st_tail) begin
            // extra beat with the icrc alone
            out_next.data                   = '0;
            out_next.data[icrc_bytes*8-1:0] = crc_hold;
            out_next.keep                   = '0;
            out_next.keep[icrc_bytes-1:0]   = '1;
            out_next.last                   = 1'b1;
            out_next.user                   = 1'b0;
            if (can_load) begin
                state_next = st_pass;
            end
        end else if (take && need_crc && !malformed) begin
            if (frame_head.keep[keep_width-1]) begin
                // beat is full, icrc goes in the next one
                out_next.last = 1'b0;
                state_next    = st_tail;
            end else begin
                out_next.data[data_width-1 -: icrc_bytes*8] = crc_head;
                out_next.keep[keep_width-1 -: icrc_bytes]   = '1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_pass;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (can_load) begin
                out_valid <= load;
            end
        end
        if (load) begin
            out_beat <= out_next;
        end
        // malformed frames pop the crc too, it is simply never used
        if (crc_pop) begin
            crc_hold <= crc_head;
        end
    end

endmodule

// ==== source/icrc_crc32_calc.sv ====
`timescale 1ns/1ps

module icrc_crc32_calc (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t masked_beat,
    input  logic                 beat_valid,
    output logic [31:0]          crc_value,
    output logic                 crc_valid
);

    import axis_pkg::*;
    import roce_pkg::*;

    logic [31:0] crc_state;
    logic [31:0] next_state;

    function automatic logic [31:0] bit_rev(input logic [31:0] v);
        logic [31:0] r;
        for (int k = 0; k < 32; k++) begin
            r[k] = v[31-k];
        end
        return r;
    endfunction

    // one byte through the reflected lfsr, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? (c >> 1) ^ bit_rev(crc_poly) : c >> 1;
        end
        return c;
    endfunction

    // bytes in stream order, keep is contiguous
    always_comb begin
        next_state = crc_state;
        for (int i = 0; i < keep_width; i++) begin
            if (masked_beat.keep[i]) begin
                next_state = crc_byte(next_state, masked_beat.data[8*i +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_state <= crc_seed;
            crc_valid <= 1'b0;
        end else begin
            crc_valid <= beat_valid && masked_beat.last && masked_beat.user[user_roce_bit];
            if (beat_valid) begin
                // every frame restarts from the prefix state
                crc_state <= masked_beat.last ? crc_seed : next_state;
            end
        end
        // first byte on the wire ends up in bits 7:0
        if (beat_valid && masked_beat.last) begin
            crc_value <= ~next_state;
        end
    end

endmodule

// ==== source/icrc_field_mask.sv ====
`timescale 1ns/1ps

module icrc_field_mask (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t in_beat,
    input  logic                 in_fire,
    output axis_pkg::axis_beat_t masked_beat,
    output axis_pkg::axis_beat_t orig_beat,
    output logic                 beat_valid
);

    import axis_pkg::*;
    import roce_pkg::*;

    logic [15:0] byte_count;
    axis_beat_t  masked_next;

    function automatic logic is_variant(input logic [15:0] off);
        // both checksums are two bytes wide
        return off == mask_tos || off == mask_ttl ||
               off == mask_ip_csum || off == mask_ip_csum + 16'd1 ||
               off == mask_udp_csum || off == mask_udp_csum + 16'd1 ||
               off == mask_bth_resv;
    endfunction

    always_comb begin
        logic [15:0] byte_off;
        masked_next = in_beat;
        for (int i = 0; i < keep_width; i++) begin
            byte_off = byte_count + 16'(i);
            if (is_variant(byte_off)) begin
                masked_next.data[8*i +: 8] = 8'hFF;
            end
        end
    end

    // offset of byte 0 of the current beat within its frame
    always_ff @(posedge clk) begin
        if (rst) begin
            byte_count <= '0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= in_fire;
            if (in_fire) begin
                byte_count <= in_beat.last ? 16'd0 : byte_count + 16'(keep_width);
            end
        end
        if (in_fire) begin
            masked_beat <= masked_next;
            orig_beat   <= in_beat;
        end
    end

endmodule

// ==== source/roce_icrc_insert.sv ====
`timescale 1ns/1ps

module roce_icrc_insert (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output axis_pkg::out_beat_t  out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    import axis_pkg::*;
    import roce_pkg::*;

    logic                                  in_fire;
    axis_beat_t                            masked_beat;
    axis_beat_t                            orig_beat;
    logic                                  beat_valid;
    logic [31:0]                           crc_value;
    logic                                  crc_valid;
    axis_beat_t                            frame_head;
    logic                                  frame_ready;
    logic                                  frame_pop;
    logic [$clog2(frame_fifo_depth+1)-1:0] frame_free;
    logic [31:0]                           crc_head;
    logic                                  crc_ready;
    logic                                  crc_pop;

    assign in_fire = in_valid && in_ready;

    // reserve covers beats still in flight toward the frame fifo
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready <= 1'b0;
        end else begin
            in_ready <= frame_free > fifo_room_margin;
        end
    end

    icrc_field_mask u_mask (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (in_beat),
        .in_fire     (in_fire),
        .masked_beat (masked_beat),
        .orig_beat   (orig_beat),
        .beat_valid  (beat_valid)
    );

    icrc_crc32_calc u_crc (
        .clk         (clk),
        .rst         (rst),
        .masked_beat (masked_beat),
        .beat_valid  (beat_valid),
        .crc_value   (crc_value),
        .crc_valid   (crc_valid)
    );

    beat_fifo #(
        .width ($bits(axis_beat_t)),
        .depth (frame_fifo_depth)
    ) u_frame_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_data    (orig_beat),
        .wr_en      (beat_valid),
        .rd_data    (frame_head),
        .rd_en      (frame_pop),
        .not_empty  (frame_ready),
        .free_count (frame_free)
    );

    // at most one entry per frame beat, so no level is needed here
    beat_fifo #(
        .width (32),
        .depth (crc_fifo_depth)
    ) u_crc_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_data    (crc_value),
        .wr_en      (crc_valid),
        .rd_data    (crc_head),
        .rd_en      (crc_pop),
        .not_empty  (crc_ready),
        .free_count ()
    );

    icrc_append u_append (
        .clk         (clk),
        .rst         (rst),
        .frame_head  (frame_head),
        .frame_ready (frame_ready),
        .frame_pop   (frame_pop),
        .crc_head    (crc_head),
        .crc_ready   (crc_ready),
        .crc_pop     (crc_pop),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// ==== source/roce_pkg.sv ====
package roce_pkg;

    // flag positions in the input user field
    localparam int user_malformed_bit = 0;
    localparam int user_roce_bit      = 1;

    // ethernet crc-32, normal form of the polynomial
    localparam logic [31:0] crc_poly = 32'h04C11DB7;

    // reflected state after the eight 0xff prefix bytes
    localparam logic [31:0] crc_seed = 32'hDEBB20E3;

    // variant fields, offsets from the start of the ipv4 header
    localparam logic [15:0] mask_tos      = 16'd1;
    localparam logic [15:0] mask_ttl      = 16'd8;
    localparam logic [15:0] mask_ip_csum  = 16'd10;
    localparam logic [15:0] mask_udp_csum = 16'd26;
    localparam logic [15:0] mask_bth_resv = 16'd32;

    // buffering
    localparam int frame_fifo_depth = 32;

    // one entry per frame, frames can be a single beat
    localparam int crc_fifo_depth = 32;

    // free beats kept back for the mask register and in_ready delay
    localparam int fifo_room_margin = 2;

    localparam int icrc_bytes = 4;

endpackage
